// ==== async_fifo.f ====
+incdir+src
src/async_fifo_pkg.sv
src/fifo_synchronizer.sv
src/fifo_write_ctl.sv
src/fifo_read_ctl.sv
src/fifo_storage.sv
src/async_fifo.sv
tb/async_fifo_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the dual-clock FIFO testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_async_fifo
LOG_FILE=sim.log
FAIL_TEXT="SIMULATION FAILED"

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator is not on the PATH"
	exit 1
fi

echo "Building with Verilator"
verilator --binary --timing -Wno-fatal \
	--top-module async_fifo_tb \
	-f async_fifo.f \
	--Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Build failed with status $status"
	exit 1
fi

echo "Running simulation"
"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if [ ! -s "$LOG_FILE" ]; then
	echo "Simulation log is empty"
	exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
	echo "Test run failed, see $LOG_FILE"
	exit 1
fi

echo "Test run finished without failure"
exit 0

// ==== src/async_fifo.sv ====
// Top level of the dual-clock FIFO joining controllers, synchronizers and storage
`timescale 1ns/1ps
`include "async_fifo_cfg.svh"

module async_fifo (
	// Shared asynchronous reset, active high
	input logic reset_rsync,

	// Read port
	input logic read_clock,
	input logic read_enable,
	output async_fifo_pkg::data_t read_data,
	output logic empty,

	// Write port
	input logic write_clock,
	input logic write_enable,
	input async_fifo_pkg::data_t write_data,
	output logic full
);

	import async_fifo_pkg::*;

	// Per-domain resets, set at once and released on their own clock
	logic read_reset;
	logic write_reset;

	// Write side toward storage
	ptr_t write_addr;
	logic write_strobe;

	// Read side toward storage
	ptr_t read_addr;

	// Gray pointers before and after crossing
	ptr_t write_gray;
	ptr_t write_gray_sync;
	ptr_t read_gray;
	ptr_t read_gray_sync;

	// Reset release in the read domain
	fifo_synchronizer #(
		.WIDTH(1),
		.RESET_STATE(1'b1)
	) read_reset_sync (
		.clk(read_clock),
		.reset(reset_rsync),
		.data_i(1'b0),
		.data_o(read_reset)
	);

	// Reset release in the write domain
	fifo_synchronizer #(
		.WIDTH(1),
		.RESET_STATE(1'b1)
	) write_reset_sync (
		.clk(write_clock),
		.reset(reset_rsync),
		.data_i(1'b0),
		.data_o(write_reset)
	);

	// Write pointer into the read domain, feeds empty
	fifo_synchronizer #(
		.WIDTH(`ASYNC_FIFO_ADDR_WIDTH),
		.RESET_STATE(1'b0)
	) write_ptr_sync (
		.clk(read_clock),
		.reset(read_reset),
		.data_i(write_gray),
		.data_o(write_gray_sync)
	);

	// Read pointer into the write domain, feeds full
	fifo_synchronizer #(
		.WIDTH(`ASYNC_FIFO_ADDR_WIDTH),
		.RESET_STATE(1'b0)
	) read_ptr_sync (
		.clk(write_clock),
		.reset(write_reset),
		.data_i(read_gray),
		.data_o(read_gray_sync)
	);

	fifo_write_ctl write_ctl (
		.write_clock(write_clock),
		.write_reset(write_reset),
		.write_enable(write_enable),
		.read_gray_sync(read_gray_sync),
		.write_addr(write_addr),
		.write_gray(write_gray),
		.write_strobe(write_strobe),
		.full(full)
	);

	fifo_read_ctl read_ctl (
		.read_clock(read_clock),
		.read_reset(read_reset),
		.read_enable(read_enable),
		.write_gray_sync(write_gray_sync),
		.read_addr(read_addr),
		.read_gray(read_gray),
		.empty(empty)
	);

	// Read data goes straight out, show-ahead
	fifo_storage storage (
		.write_clock(write_clock),
		.write_strobe(write_strobe),
		.write_addr(write_addr),
		.write_data(write_data),
		.read_addr(read_addr),
		.read_data(read_data)
	);

endmodule

// ==== src/async_fifo_cfg.svh ====
// Size and synchronizer depth macros for the dual-clock FIFO
`ifndef ASYNC_FIFO_CFG_SVH
`define ASYNC_FIFO_CFG_SVH

// Bits in one data word
`define ASYNC_FIFO_WIDTH 32

// Storage entries, a power of two of at least 2
`define ASYNC_FIFO_DEPTH 8

// Address bits, follows the depth
// Pointers are this wide too, so one entry always stays unused
`define ASYNC_FIFO_ADDR_WIDTH ($clog2(`ASYNC_FIFO_DEPTH))

// Flip-flops in each clock crossing chain
// Two is the usual minimum for metastability settling
`define ASYNC_FIFO_SYNC_STAGES 2

`endif

// ==== src/async_fifo_pkg.sv ====
// Package with the data word and pointer vector types of the dual-clock FIFO
`include "async_fifo_cfg.svh"

package async_fifo_pkg;

	// One word as it is written and read
	typedef logic [`ASYNC_FIFO_WIDTH-1:0] data_t;

	// Pointer or storage address
	// Same width for the binary and the Gray form
	// The binary form indexes the array directly
	typedef logic [`ASYNC_FIFO_ADDR_WIDTH-1:0] ptr_t;

endpackage

// ==== src/fifo_read_ctl.sv ====
// Read-domain pointer, Gray conversion and empty flag of the dual-clock FIFO
`timescale 1ns/1ps

module fifo_read_ctl (
	input logic read_clock,
	input logic read_reset,
	input logic read_enable,
	input async_fifo_pkg::ptr_t write_gray_sync,
	output async_fifo_pkg::ptr_t read_addr,
	output async_fifo_pkg::ptr_t read_gray,
	output logic empty
);

	import async_fifo_pkg::*;

	// Binary pointer selects the word shown on read_data
	ptr_t read_ptr;
	// Gray copy crosses to the write side
	ptr_t read_gray_q;

	// Next position in both encodings
	ptr_t read_ptr_next;
	ptr_t read_gray_next;

	// Accepted read, a read while empty does nothing
	logic read_strobe;

	assign read_ptr_next = read_ptr + 1'b1;
	// Binary to Gray
	assign read_gray_next = read_ptr_next ^ (read_ptr_next >> 1);

	// Empty when the write pointer as seen here has not moved past us
	// A fresh write shows up once its pointer clears the synchronizer
	assign empty = (write_gray_sync == read_gray_q);

	assign read_strobe = read_enable & ~empty;

	always_ff @(posedge read_clock or posedge read_reset)
	begin
		if (read_reset)
		begin
			read_ptr <= '0;
			read_gray_q <= '0;
		end
		else if (read_strobe)
		begin
			// Advance to the next word, data shows up without a clock
			read_ptr <= read_ptr_next;
			read_gray_q <= read_gray_next;
		end
	end

	// Array is read combinationally at this address
	// so the head word is valid whenever empty is low
	assign read_addr = read_ptr;

	// Registered Gray value goes to the write-side synchronizer
	assign read_gray = read_gray_q;

endmodule

// ==== src/fifo_storage.sv ====
// Dual-port word array with clocked write and combinational read
`timescale 1ns/1ps
`include "async_fifo_cfg.svh"

module fifo_storage (
	input logic write_clock,
	input logic write_strobe,
	input async_fifo_pkg::ptr_t write_addr,
	input async_fifo_pkg::data_t write_data,
	input async_fifo_pkg::ptr_t read_addr,
	output async_fifo_pkg::data_t read_data
);

	import async_fifo_pkg::*;

	localparam int DEPTH = `ASYNC_FIFO_DEPTH;

	// One word per entry
	data_t fifo_mem [0:DEPTH-1];

	// Known contents at time zero
	// keeps read_data clean before the first write
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
		begin
			fifo_mem[i] = '0;
		end
	end

	// Write port in the write_clock domain
	// Strobe already carries the full check
	always @(posedge write_clock)
	begin
		if (write_strobe)
		begin
			fifo_mem[write_addr] <= write_data;
		end
	end

	// Read port has no clock
	// Head word is on read_data ahead of the read strobe
	// An entry is never written while it is still unread
	assign read_data = fifo_mem[read_addr];

endmodule

// ==== src/fifo_synchronizer.sv ====
// Multi-stage flip-flop synchronizer with a settable reset value
`timescale 1ns/1ps
`include "async_fifo_cfg.svh"

module fifo_synchronizer #(
	// 1 for a reset level, the address width for a Gray pointer
	parameter int WIDTH = 1,
	// Value every bit takes while reset is high
	parameter logic RESET_STATE = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic [WIDTH-1:0] data_i,
	output logic [WIDTH-1:0] data_o
);

	localparam int STAGES = `ASYNC_FIFO_SYNC_STAGES;

	// Stage 0 samples the foreign value
	// Last stage is the settled copy in clk's domain
	logic [STAGES-1:0][WIDTH-1:0] sync_q;

	// Asynchronous set or clear, release follows clk through the chain
	// For a reset instance the input is 0 and RESET_STATE is 1
	// so assertion is immediate and release takes STAGES edges
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			sync_q <= {STAGES{{WIDTH{RESET_STATE}}}};
		end
		else
		begin
			// Shift toward the output end
			sync_q <= {sync_q[STAGES-2:0], data_i};
		end
	end

	// Only one bit of a Gray pointer moves per step
	// so the sampled value is either old or new, never a mix
	assign data_o = sync_q[STAGES-1];

endmodule

// ==== src/fifo_write_ctl.sv ====
// Write-domain pointer, Gray conversion and full flag of the dual-clock FIFO
`timescale 1ns/1ps

module fifo_write_ctl (
	input logic write_clock,
	input logic write_reset,
	input logic write_enable,
	input async_fifo_pkg::ptr_t read_gray_sync,
	output async_fifo_pkg::ptr_t write_addr,
	output async_fifo_pkg::ptr_t write_gray,
	output logic write_strobe,
	output logic full
);

	import async_fifo_pkg::*;

	// Binary pointer addresses the array
	ptr_t write_ptr;
	// Gray copy is the only form that leaves this domain
	ptr_t write_gray_q;

	// Next position in both encodings
	ptr_t write_ptr_next;
	ptr_t write_gray_next;

	// Increment wraps at the depth
	assign write_ptr_next = write_ptr + 1'b1;
	// Binary to Gray, each bit xor its upper neighbour
	assign write_gray_next = write_ptr_next ^ (write_ptr_next >> 1);

	// Full when one more write would land on the read pointer
	// Read pointer is a few cycles old here, so full may linger
	// but it never lets a write overrun unread data
	assign full = (write_gray_next == read_gray_sync);

	// Accepted write, a write while full is dropped
	assign write_strobe = write_enable & ~full;

	always_ff @(posedge write_clock or posedge write_reset)
	begin
		if (write_reset)
		begin
			write_ptr <= '0;
			write_gray_q <= '0;
		end
		else if (write_strobe)
		begin
			// Both encodings move together on an accepted write
			write_ptr <= write_ptr_next;
			write_gray_q <= write_gray_next;
		end
	end

	// Storage writes at the current binary position
	assign write_addr = write_ptr;

	// Registered Gray value goes to the read-side synchronizer
	assign write_gray = write_gray_q;

endmodule

// ==== tb/async_fifo_tb.sv ====
// Testbench for the dual-clock FIFO with phase table, LFSR data, queue model, checker and watchdog
`timescale 1ns/1ps
`include "async_fifo_cfg.svh"

module async_fifo_tb;

	import async_fifo_pkg::*;

	// Clock periods in ns
	// Read side is the slower one
	localparam int READ_PERIOD = 40;
	localparam int WRITE_PERIOD = 28;
	// Inputs change this long after their own rising edge
	localparam int DRIVE_DELAY = 2;
	localparam int SETTLE_CYCLES = 4;
	localparam int NUM_PHASES = 9;

	// One row of stimulus and the flag levels expected after it
	typedef struct packed {
		int do_reset;
		int wr_count;
		int wr_gap;
		int wr_force;
		int rd_count;
		int rd_gap;
		int rd_force;
		int concurrent;
		int exp_full;
		int exp_empty;
		int exp_level;
	} phase_t;

	// rst, writes gap force, reads gap force, conc, full empty level
	localparam phase_t PHASES [NUM_PHASES] = '{
		'{0, 0, 0, 0, 3, 0, 1, 0, 0, 1, 0},
		'{0, 10, 0, 1, 0, 0, 0, 0, 1, 0, `ASYNC_FIFO_DEPTH - 1},
		'{0, 0, 0, 0, `ASYNC_FIFO_DEPTH - 1, 0, 0, 0, 0, 1, 0},
		'{0, 40, 0, 0, 40, 1, 0, 1, 0, 1, 0},
		'{0, 20, 3, 1, 80, 0, 1, 1, 0, 1, 0},
		'{0, 30, 1, 0, 30, 0, 0, 1, 0, 1, 0},
		'{0, 10, 0, 1, 0, 0, 0, 0, 1, 0, `ASYNC_FIFO_DEPTH - 1},
		'{1, 4, 0, 0, 0, 0, 0, 0, 0, 0, 4},
		'{0, 0, 0, 0, 4, 0, 0, 0, 0, 1, 0}
	};

	// DUT ports
	logic reset_rsync;
	logic read_clock;
	logic read_enable;
	data_t read_data;
	logic empty;
	logic write_clock;
	logic write_enable;
	data_t write_data;
	logic full;

	// Words accepted by the DUT and not yet read in write order
	data_t model_q [$];

	logic [31:0] lfsr_state = 32'hc414_e40e;
	int check_count = 0;
	int value_errors = 0;
	int other_errors = 0;

	async_fifo UUT (
		.reset_rsync(reset_rsync),
		.read_clock(read_clock),
		.read_enable(read_enable),
		.read_data(read_data),
		.empty(empty),
		.write_clock(write_clock),
		.write_enable(write_enable),
		.write_data(write_data),
		.full(full)
	);

	always #(READ_PERIOD / 2) read_clock = ~read_clock;
	always #(WRITE_PERIOD / 2) write_clock = ~write_clock;

	// Galois step with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per data bit
	function automatic data_t random_word();
		data_t w;
		w = '0;
		for (int b = 0; b < `ASYNC_FIFO_WIDTH; b++)
		begin
			w = {w[`ASYNC_FIFO_WIDTH-2:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return w;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			value_errors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// Move to the next drive point of each domain
	task automatic step_write();
		@(posedge write_clock);
		#(DRIVE_DELAY);
	endtask

	task automatic step_read();
		@(posedge read_clock);
		#(DRIVE_DELAY);
	endtask

	// Without force an attempt waits for full to drop
	task automatic run_writes(input int count, input int gap, input int force_it);
		for (int i = 0; i < count; i++)
		begin
			step_write();
			if (force_it == 0)
			begin
				while (full)
				begin
					step_write();
				end
			end
			write_enable = 1'b1;
			write_data = random_word();
			// Full is steady between write edges so the next edge decides
			@(negedge write_clock);
			if (!full)
			begin
				model_q.push_back(write_data);
			end
			step_write();
			write_enable = 1'b0;
			repeat (gap) step_write();
		end
	endtask

	// Without force an attempt waits for empty to drop
	task automatic run_reads(input int count, input int gap, input int force_it);
		data_t expected;
		for (int i = 0; i < count; i++)
		begin
			step_read();
			if (force_it == 0)
			begin
				while (empty)
				begin
					step_read();
				end
			end
			read_enable = 1'b1;
			// Show-ahead data is sampled before the accepting edge
			@(negedge read_clock);
			if (!empty)
			begin
				if (model_q.size() == 0)
				begin
					other_errors++;
					$display("At %0t ns the FIFO offered a word that was never written", $time);
				end
				else
				begin
					expected = model_q.pop_front();
					check_value("read_data", read_data, expected);
				end
			end
			step_read();
			read_enable = 1'b0;
			repeat (gap) step_read();
		end
	endtask

	// Pointer crossings finish within a few edges of either clock
	task automatic settle();
		repeat (SETTLE_CYCLES) @(posedge read_clock);
		repeat (2) @(posedge write_clock);
	endtask

	task automatic check_flags(input int exp_full, input int exp_empty, input int exp_level);
		@(negedge read_clock);
		check_value("empty", 32'(empty), 32'(exp_empty));
		@(negedge write_clock);
		check_value("full", 32'(full), 32'(exp_full));
		check_value("words held", 32'(model_q.size()), 32'(exp_level));
	endtask

	// Reset is held for two read cycles
	// Flags clear as soon as it rises
	task automatic apply_reset();
		step_read();
		read_enable = 1'b0;
		write_enable = 1'b0;
		reset_rsync = 1'b1;
		#1;
		check_value("empty in reset", 32'(empty), 32'd1);
		check_value("full in reset", 32'(full), 32'd0);
		repeat (2) @(posedge read_clock);
		#(DRIVE_DELAY);
		reset_rsync = 1'b0;
		// Contents before the reset are gone
		model_q.delete();
		settle();
	endtask

	// Sum of all attempts and gaps counted in the slower clock
	function automatic longint watchdog_limit();
		longint cycles;
		cycles = 8;
		for (int p = 0; p < NUM_PHASES; p++)
		begin
			cycles += PHASES[p].wr_count * (PHASES[p].wr_gap + 2);
			cycles += PHASES[p].rd_count * (PHASES[p].rd_gap + 2);
			cycles += 2 * SETTLE_CYCLES + 4;
		end
		return cycles * READ_PERIOD + 5000;
	endfunction

	initial
	begin
		#(watchdog_limit());
		$display("Timeout: the tests did not finish within %0d ns", watchdog_limit());
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		phase_t ph;
		read_clock = 1'b0;
		write_clock = 1'b0;
		read_enable = 1'b0;
		write_enable = 1'b0;
		write_data = '0;
		reset_rsync = 1'b1;
		repeat (2) @(posedge read_clock);
		#(DRIVE_DELAY);
		reset_rsync = 1'b0;
		settle();
		// Out of reset the FIFO is empty and not full
		check_flags(0, 1, 0);
		for (int p = 0; p < NUM_PHASES; p++)
		begin
			ph = PHASES[p];
			if (ph.do_reset != 0)
			begin
				apply_reset();
			end
			if (ph.concurrent != 0)
			begin
				fork
					run_writes(ph.wr_count, ph.wr_gap, ph.wr_force);
					run_reads(ph.rd_count, ph.rd_gap, ph.rd_force);
				join
			end
			else
			begin
				run_writes(ph.wr_count, ph.wr_gap, ph.wr_force);
				run_reads(ph.rd_count, ph.rd_gap, ph.rd_force);
			end
			settle();
			check_flags(ph.exp_full, ph.exp_empty, ph.exp_level);
		end
		$display("Summary: %0d checks, %0d value errors, %0d other failures",
			check_count, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
